/* all.f */
hdl/bridge_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_ctrl.sv
hdl/mem_array.sv
hdl/uart_mem_bridge.sv
tests/tb_clock.sv
tests/bridge_props.sv
tests/tb_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_bridge -f all.f -o sim_bridge

./obj_dir/sim_bridge | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"

/* tests/tb_bridge.sv */
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the UART memory bridge. Sends commands
// serially, recovers replies from tx_line and checks them.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_bridge;
    import bridge_pkg::*;

    localparam int          CLK_DIV       = 8;
    localparam int          ADDR_W        = 10;
    localparam int          CLK_PERIOD_NS = 40;
    localparam int          RST_CYCLES    = 16;
    localparam int          FRAME_CYCLES  = 10 * CLK_DIV;
    localparam int          MEM_SIZE      = 1 << ADDR_W;
    localparam int          N_CMDS        = 17;
    localparam logic [31:0] SEED          = 32'h67590d9f;

    typedef struct packed {
        byte_t       opcode;
        logic [15:0] addr;
        byte_t       len;
        byte_t       seed;                  // xored into random write data
        logic        bad_frame;             // address high byte gets a low stop bit
        logic        chain;                 // next command follows without a wait
    } cmd_t;

    cmd_t cmds [N_CMDS] = '{
        '{OP_WRITE, 16'h0010, 8'd6,  8'h11, 1'b0, 1'b0},
        '{OP_READ,  16'h0010, 8'd6,  8'h00, 1'b0, 1'b0},
        '{OP_WRITE, 16'h0100, 8'd20, 8'h5a, 1'b0, 1'b0},
        '{OP_READ,  16'h0100, 8'd20, 8'h00, 1'b0, 1'b0},  // longer than the queue
        '{OP_WRITE, 16'h03fd, 8'd6,  8'hc3, 1'b0, 1'b0},  // wraps past the top
        '{OP_READ,  16'h03fd, 8'd6,  8'h00, 1'b0, 1'b0},
        '{8'h33,    16'h0000, 8'd1,  8'h00, 1'b0, 1'b0},
        '{OP_READ,  16'h0010, 8'd3,  8'h00, 1'b0, 1'b0},
        '{OP_WRITE, 16'h0000, 8'd2,  8'h00, 1'b1, 1'b0},
        '{OP_WRITE, 16'h0020, 8'd4,  8'h77, 1'b0, 1'b0},
        '{OP_READ,  16'h0020, 8'd4,  8'h00, 1'b0, 1'b0},
        '{OP_WRITE, 16'h0200, 8'd4,  8'h0f, 1'b0, 1'b1},  // back-to-back group
        '{OP_READ,  16'h0200, 8'd2,  8'h00, 1'b0, 1'b1},
        '{OP_WRITE, 16'h02f0, 8'd3,  8'he1, 1'b0, 1'b1},
        '{8'ha5,    16'h0123, 8'd9,  8'h00, 1'b0, 1'b1},
        '{OP_READ,  16'h02f0, 8'd2,  8'h00, 1'b0, 1'b1},
        '{OP_READ,  16'h0201, 8'd3,  8'h00, 1'b0, 1'b0}
    };

    logic     clk;
    logic     rst_n;
    logic     rx_line;
    logic     tx_line;

    byte_t    ref_mem [MEM_SIZE];           // what the memory should hold
    byte_t    exp_q [$];
    byte_t    got_q [$];                    // bytes recovered from tx_line
    rx_byte_t sent_q [$];                   // frames the driver has sent
    int       pend_idx [$];
    int       pend_cnt [$];
    int       errors   = 0;
    int       n_checks = 0;
    int       n_pass   = 0;
    int       n_fail   = 0;

    tb_clock #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_mem_bridge #(
        .CLK_DIV (CLK_DIV),
        .ADDR_W  (ADDR_W)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_line (rx_line),
        .tx_line (tx_line)
    );

    task automatic check_byte(input byte_t got, input byte_t exp, input string name);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input rx_byte_t got, input rx_byte_t exp, input string name);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %02h/%b expected %02h/%b", $time, name,
                     got.data, got.frame_err, exp.data, exp.frame_err);
        end
    endtask

    function automatic string op_label(input cmd_t c);
        if (c.bad_frame) begin
            return "frame error";
        end else if (c.opcode == OP_WRITE) begin
            return "write";
        end else if (c.opcode == OP_READ) begin
            return "read";
        end
        return "unknown op";
    endfunction

    // serial bytes the whole table moves, both directions
    function automatic longint table_bytes();
        longint n;
        n = 0;
        for (int i = 0; i < N_CMDS; i++) begin
            n += 4;
            if (cmds[i].bad_frame || cmds[i].opcode != OP_READ) begin
                n += 1;
            end else begin
                n += longint'(cmds[i].len);
            end
            if (!cmds[i].bad_frame && cmds[i].opcode == OP_WRITE) begin
                n += longint'(cmds[i].len);
            end
        end
        return n;
    endfunction

    task automatic drive_bit(input logic level);
        @(posedge clk);
        rx_line <= level;
        repeat (CLK_DIV - 1) @(posedge clk);
    endtask

    task automatic send_frame(input byte_t data, input logic bad_stop);
        rx_byte_t sent;
        byte_t    bits;
        sent.data      = data;
        sent.frame_err = bad_stop;
        sent_q.push_back(sent);
        bits = data;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(bits[0]);             // lsb first
            bits = bits >> 1;
        end
        drive_bit(!bad_stop);
        if (bad_stop) begin
            drive_bit(1'b1);                // line must rise before the next start
        end
    endtask

    task automatic run_cmd(input int idx);
        cmd_t              c;
        byte_t             d;
        logic [ADDR_W-1:0] a;
        c = cmds[idx];
        pend_idx.push_back(idx);
        if (c.bad_frame) begin
            send_frame(c.opcode, 1'b0);
            send_frame(c.addr[15:8], 1'b1);
            exp_q.push_back(RSP_FRAME_ERR);
            pend_cnt.push_back(1);
        end else begin
            send_frame(c.opcode, 1'b0);
            send_frame(c.addr[15:8], 1'b0);
            send_frame(c.addr[7:0], 1'b0);
            send_frame(c.len, 1'b0);
            if (c.opcode == OP_WRITE) begin
                for (int k = 0; k < int'(c.len); k++) begin
                    d = byte_t'($urandom) ^ c.seed;
                    a = ADDR_W'(int'(c.addr) + k);  // wraps at the memory size
                    ref_mem[a] = d;
                    send_frame(d, 1'b0);
                end
                exp_q.push_back(RSP_ACK);
                pend_cnt.push_back(1);
            end else if (c.opcode == OP_READ) begin
                for (int k = 0; k < int'(c.len); k++) begin
                    a = ADDR_W'(int'(c.addr) + k);
                    exp_q.push_back(ref_mem[a]);
                end
                pend_cnt.push_back(int'(c.len));
            end else begin
                exp_q.push_back(RSP_BAD_OP);
                pend_cnt.push_back(1);
            end
        end
    endtask

    // compares replies of all commands sent since the last wait
    task automatic collect_replies();
        int total;
        int idx;
        int cnt;
        int errs_before;
        total = exp_q.size();
        while (got_q.size() < total) begin
            @(posedge clk);
        end
        repeat (2 * FRAME_CYCLES) @(posedge clk);   // room for stray extra bytes
        while (pend_idx.size() > 0) begin
            idx         = pend_idx.pop_front();
            cnt         = pend_cnt.pop_front();
            errs_before = errors;
            for (int k = 0; k < cnt; k++) begin
                check_byte(got_q.pop_front(), exp_q.pop_front(),
                           $sformatf("test %0d reply byte %0d", idx, k));
            end
            if (pend_idx.size() == 0 && got_q.size() != 0) begin
                errors++;
                $display("test %0d: %0d more reply bytes arrived than expected",
                         idx, got_q.size());
                got_q.delete();
            end
            if (errors == errs_before) begin
                n_pass++;
            end else begin
                n_fail++;
            end
            $display("test %0d %s addr %03h len %0d: %s", idx, op_label(cmds[idx]),
                     cmds[idx].addr, cmds[idx].len, (errors == errs_before) ? "pass" : "fail");
        end
    endtask

    initial begin : tx_monitor
        byte_t data;
        forever begin
            @(posedge clk);
            if (rst_n && tx_line === 1'b0) begin
                repeat (CLK_DIV / 2 - 1) @(posedge clk);    // middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLK_DIV) @(posedge clk);
                    data = {tx_line, data[7:1]};
                end
                repeat (CLK_DIV) @(posedge clk);
                if (tx_line !== 1'b1) begin
                    errors++;
                    $display("tx_line stop bit was low at %0t ns", $time);
                end
                got_q.push_back(data);
            end
        end
    end

    // the receiver must hand over exactly what the driver sent
    always @(posedge clk) begin
        if (rst_n && i_dut.rx_valid) begin
            if (sent_q.size() == 0) begin
                errors++;
                $display("receiver delivered a byte that was never sent");
            end else begin
                check_frame(i_dut.rx_byte, sent_q.pop_front(), "rx_byte");
            end
        end
    end

    initial begin : watchdog
        longint limit;
        limit = 2 * table_bytes() * FRAME_CYCLES * CLK_PERIOD_NS
              + RST_CYCLES * CLK_PERIOD_NS;
        #(limit);
        $display("timeout: replies still missing after %0d ns", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rx_line = 1'b1;
        void'($urandom(SEED));
        @(posedge rst_n);
        repeat (4) @(posedge clk);
        for (int i = 0; i < N_CMDS; i++) begin
            run_cmd(i);
            if (!cmds[i].chain) begin
                collect_replies();
            end
        end
        $display("tests %0d passed %0d failed %0d checks %0d errors %0d",
                 n_pass + n_fail, n_pass, n_fail, n_checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/bridge_props.sv */
//////////////////////////////////////////////////////////////////////
// Credit and memory handshake properties of the command controller,
// bound into every cmd_ctrl instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cmd_ctrl_props (
    input wire logic                                         clk,
    input wire logic                                         rst_n,
    input wire logic                                         rx_valid,
    input wire logic                                         tx_push,
    input wire logic                                         tx_credit,
    input wire logic [$clog2(bridge_pkg::TX_CREDITS + 1)-1:0] credits,
    input wire bridge_pkg::mem_req_t                         mem_req
);
    import bridge_pkg::*;

    logic       seen_rx;                // a byte has arrived since reset
    logic [2:0] tx_held;                // pushed bytes not yet handed back as credits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_rx <= 1'b0;
            tx_held <= '0;
        end else begin
            tx_held <= tx_held + 3'(tx_push) - 3'(tx_credit);
            if (rx_valid) begin
                seen_rx <= 1'b1;
            end
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credits) <= TX_CREDITS)
        else $error("free credit count above transmit queue depth");

    push_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        tx_push |-> (int'(tx_held) - int'(tx_credit) < TX_CREDITS))
        else $error("push to transmitter without a credit");

    write_after_rx: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && mem_req.we) |-> $past(rx_valid))
        else $error("memory write not preceded by a received byte");

    quiet_until_rx: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_rx |-> (!tx_push && !mem_req.valid))
        else $error("controller active before the first received byte");

endmodule

bind cmd_ctrl cmd_ctrl_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .tx_push   (tx_push),
    .tx_credit (tx_credit),
    .credits   (credits),
    .mem_req   (mem_req)
);

`default_nettype wire

/* tests/tb_clock.sv */
//////////////////////////////////////////////////////////////////////
// Clock and reset source for the bridge testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                  // release on a rising edge
    end

endmodule

`default_nettype wire

/* hdl/uart_mem_bridge.sv */
//////////////////////////////////////////////////////////////////////
// Top level of the serial memory loader. Commands arrive on rx_line,
// replies and read data leave on tx_line.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_mem_bridge #(
    parameter int CLK_DIV = 8,          // clocks per bit
    parameter int ADDR_W  = 10
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic rx_line,
    output logic      tx_line
);
    import bridge_pkg::*;

    rx_byte_t rx_byte;
    logic     rx_valid;
    mem_req_t mem_req;
    byte_t    mem_rdata;
    logic     tx_push;
    byte_t    tx_data;
    logic     tx_credit;

    uart_rx #(
        .CLK_DIV (CLK_DIV)
    ) i_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_ctrl #(
        .ADDR_W (ADDR_W)
    ) i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .tx_push   (tx_push),
        .tx_data   (tx_data),
        .tx_credit (tx_credit)
    );

    mem_array #(
        .ADDR_W (ADDR_W)
    ) i_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    uart_tx #(
        .CLK_DIV (CLK_DIV)
    ) i_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_push   (tx_push),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .tx_line   (tx_line)
    );

endmodule

`default_nettype wire

/* hdl/mem_array.sv */
//////////////////////////////////////////////////////////////////////
// Single-port byte memory of 2**ADDR_W entries. Writes on the clock
// edge, read data appears one cycle after the request.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_array #(
    parameter int ADDR_W = 10
) (
    input  wire logic                 clk,
    input  wire bridge_pkg::mem_req_t mem_req,
    output bridge_pkg::byte_t         rdata
);
    import bridge_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    byte_t             mem [DEPTH];
    logic [ADDR_W-1:0] idx;

    assign idx = mem_req.addr[ADDR_W-1:0];  // upper bits ignored

    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            if (mem_req.we) begin
                mem[idx] <= mem_req.wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cmd_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Command parser and sequencer. Turns received header and data bytes
// into memory accesses and pushes replies against transmit credits.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cmd_ctrl #(
    parameter int ADDR_W = 10
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire bridge_pkg::rx_byte_t rx_byte,
    input  wire logic                 rx_valid,
    output bridge_pkg::mem_req_t      mem_req,
    input  wire bridge_pkg::byte_t    mem_rdata,
    output logic                      tx_push,
    output bridge_pkg::byte_t         tx_data,
    input  wire logic                 tx_credit
);
    import bridge_pkg::*;

    localparam int CRW = $clog2(TX_CREDITS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR_HI,
        S_ADDR_LO,
        S_LENGTH,
        S_WRITE_DATA,
        S_READ_ISSUE,
        S_REPLY
    } state_t;

    state_t            state;
    byte_t             opcode;
    logic [ADDR_W-1:0] addr;
    byte_t             remain;          // bytes left in the command
    byte_t             rsp_code;
    logic [CRW-1:0]    credits;         // free, reads in flight already taken
    logic              rd_pend;         // read data returns this cycle
    logic              frame_err;
    logic              wr_go;
    logic              rd_go;
    logic              rsp_go;

    assign frame_err = rx_valid && rx_byte.frame_err;
    assign wr_go     = (state == S_WRITE_DATA) && rx_valid && !rx_byte.frame_err;
    assign rd_go     = (state == S_READ_ISSUE) && (credits != '0) && !frame_err;
    assign rsp_go    = (state == S_REPLY) && (credits != '0) && !rd_pend;

    // read data has the port to itself when it returns
    assign tx_push = rd_pend || rsp_go;
    assign tx_data = rd_pend ? mem_rdata : rsp_code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            opcode   <= '0;
            addr     <= '0;
            remain   <= '0;
            rsp_code <= '0;
            credits  <= CRW'(TX_CREDITS);
            rd_pend  <= 1'b0;
            mem_req  <= '0;
        end else begin
            rd_pend       <= mem_req.valid && !mem_req.we;
            credits       <= credits + CRW'(tx_credit) - CRW'(rd_go) - CRW'(rsp_go);
            mem_req.valid <= rd_go || wr_go;
            mem_req.we    <= wr_go;
            if (rd_go || wr_go) begin
                mem_req.addr <= MAX_ADDR_W'(addr);
                addr         <= addr + 1'b1;    // wraps at memory size
                remain       <= remain - 1'b1;
            end
            if (wr_go) begin
                mem_req.wdata <= rx_byte.data;
            end
            if (frame_err && state != S_REPLY) begin
                state    <= S_REPLY;            // abandon command
                rsp_code <= RSP_FRAME_ERR;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (rx_valid) begin
                            opcode <= rx_byte.data;
                            state  <= S_ADDR_HI;
                        end
                    end
                    S_ADDR_HI, S_ADDR_LO: begin
                        if (rx_valid) begin
                            addr  <= ADDR_W'({addr, rx_byte.data});  // shift in, msb first
                            state <= (state == S_ADDR_HI) ? S_ADDR_LO : S_LENGTH;
                        end
                    end
                    S_LENGTH: begin
                        // opcode is judged once the whole header is in
                        if (rx_valid) begin
                            remain <= rx_byte.data;
                            if (opcode == OP_WRITE) begin
                                state <= S_WRITE_DATA;
                            end else if (opcode == OP_READ) begin
                                state <= S_READ_ISSUE;
                            end else begin
                                state    <= S_REPLY;
                                rsp_code <= RSP_BAD_OP;
                            end
                        end
                    end
                    S_WRITE_DATA: begin
                        if (wr_go && remain == 8'd1) begin
                            state    <= S_REPLY;
                            rsp_code <= RSP_ACK;
                        end
                    end
                    S_READ_ISSUE: begin
                        if (rd_go && remain == 8'd1) begin
                            state <= S_IDLE;    // last data still in flight
                        end
                    end
                    S_REPLY: begin
                        if (rsp_go) begin
                            state <= S_IDLE;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
//////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1, with a small holding queue. Each byte that
// leaves the queue returns one credit to the sender.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int CLK_DIV = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 tx_push,
    input  wire bridge_pkg::byte_t    tx_data,
    output logic                      tx_credit,
    output logic                      tx_line
);
    import bridge_pkg::*;

    localparam int CW = $clog2(CLK_DIV);
    localparam int QW = $clog2(TX_CREDITS);
    localparam logic [CW-1:0] BIT_LAST = CW'(CLK_DIV - 1);

    byte_t         queue [TX_CREDITS];
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [QW:0]   count;
    logic          busy;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_idx;             // 0 start, 1..8 data, 9 stop
    logic [8:0]    shift;               // stop bit above the data
    byte_t         head;
    logic          frame_end;
    logic          step;
    logic          load;
    logic          pop;
    logic          wr_en;

    assign frame_end = busy && (cnt == '0) && (bit_idx == 4'd9);
    assign step      = busy && (cnt == '0) && !frame_end;
    assign load      = (!busy || frame_end) && ((count != '0) || tx_push);
    assign pop       = load && (count != '0);
    assign wr_en     = tx_push && !(load && (count == '0));  // empty queue bypassed
    assign head      = (count != '0) ? queue[rd_ptr] : tx_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            busy      <= 1'b0;
            cnt       <= '0;
            bit_idx   <= '0;
            tx_credit <= 1'b0;
            tx_line   <= 1'b1;
        end else begin
            tx_credit <= load;                  // first cycle of the start bit
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (QW + 1)'(wr_en) - (QW + 1)'(pop);
            if (load) begin
                busy    <= 1'b1;
                cnt     <= BIT_LAST;
                bit_idx <= '0;
                tx_line <= 1'b0;
            end else if (frame_end) begin
                busy <= 1'b0;
            end else if (step) begin
                cnt     <= BIT_LAST;
                bit_idx <= bit_idx + 1'b1;
                tx_line <= shift[0];
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            queue[wr_ptr] <= tx_data;
        end
        if (load) begin
            shift <= {1'b1, head};
        end else if (step) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
//////////////////////////////////////////////////////////////////////
// UART receiver, 8N1, CLK_DIV clocks per bit. Emits a one-cycle
// rx_valid strobe per byte, with frame_err set on a low stop bit.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
    parameter int CLK_DIV = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rx_line,
    output bridge_pkg::rx_byte_t      rx_byte,
    output logic                      rx_valid
);
    import bridge_pkg::*;

    localparam int CW = $clog2(CLK_DIV);
    localparam logic [CW-1:0] BIT_LAST  = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] HALF_LAST = CW'(CLK_DIV / 2 - 1);

    logic [1:0]    sync;                // two-flop synchronizer
    logic          line_q;              // last synced level, for edge detect
    logic          busy;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_idx;             // 0 start, 1..8 data, 9 stop
    byte_t         shift;
    logic          sample;

    assign sample = busy && (cnt == '0);    // middle of current bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync     <= 2'b11;
            line_q   <= 1'b1;
            busy     <= 1'b0;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], rx_line};
            line_q   <= sync[1];
            rx_valid <= 1'b0;
            if (!busy) begin
                if (line_q && !sync[1]) begin   // falling edge opens a frame
                    busy    <= 1'b1;
                    cnt     <= HALF_LAST;
                    bit_idx <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt     <= BIT_LAST;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && sync[1]) begin
                    busy <= 1'b0;               // glitch, line back high
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shift <= {sync[1], shift[7:1]};    // lsb first
            end
            if (bit_idx == 4'd9) begin
                rx_byte.data      <= shift;
                rx_byte.frame_err <= !sync[1];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bridge_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Types, opcodes and reply codes shared by the UART memory bridge
// and its testbench. Import where the bus structs are needed.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bridge_pkg;

    localparam int MAX_ADDR_W = 16;     // widest memory the bus can address
    localparam int TX_CREDITS = 2;      // transmit queue depth

    typedef logic [7:0] byte_t;

    // byte as delivered by the receiver
    typedef struct packed {
        byte_t data;
        logic  frame_err;               // stop bit was low
    } rx_byte_t;

    // one memory access, valid for a single cycle
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [MAX_ADDR_W-1:0] addr;    // upper bits unused on small memories
        byte_t                 wdata;
    } mem_req_t;

    localparam byte_t OP_WRITE = 8'h57;
    localparam byte_t OP_READ  = 8'h52;

    localparam byte_t RSP_ACK       = 8'h4B;
    localparam byte_t RSP_BAD_OP    = 8'h3F;
    localparam byte_t RSP_FRAME_ERR = 8'h21;

endpackage

`default_nettype wire
